/* src/muldiv_pkg.sv */
//--------------------------------------------------------------------------
// muldiv package
// opcode and controller state encodings shared by the muldiv unit
//--------------------------------------------------------------------------

package muldiv_pkg;

  // request opcode
  // signed ops take absolute values first and fix the sign at the end
  typedef enum logic [1:0] {
    MD_MUL  = 2'd0,
    MD_MULU = 2'd1,
    MD_DIV  = 2'd2,
    MD_DIVU = 2'd3
  } muldiv_fn_e;

  // controller states
  // one operation at a time so three states are enough
  typedef enum logic [1:0] {
    ST_IDLE = 2'd0,
    ST_CALC = 2'd1,
    ST_DONE = 2'd2
  } muldiv_state_e;

endpackage

/* src/step_ctrl_if.sv */
//--------------------------------------------------------------------------
// step control interface
// strobes from the muldiv controller to the datapath blocks
//--------------------------------------------------------------------------

`timescale 1ns/1ps

interface step_ctrl_if;

  // capture operands, high only in the accepting cycle
  logic load;
  // one iteration per cycle while calculating
  logic step;
  // opcode decode
  // follows req_fn while idle and the registered opcode afterwards
  logic is_signed;
  logic is_mul;

  // controller side
  modport ctrl (
    output load,
    output step,
    output is_signed,
    output is_mul
  );

  // datapath side
  modport dpath (
    input load,
    input step,
    input is_signed,
    input is_mul
  );

endinterface

/* src/muldiv_ctrl.sv */
//--------------------------------------------------------------------------
// muldiv controller
// request/response handshakes, iteration count and datapath strobes
//--------------------------------------------------------------------------

`timescale 1ns/1ps

module muldiv_ctrl
  import muldiv_pkg::*;
#(
  parameter int WIDTH = 32
) (
  input  logic       clk,
  input  logic       reset,
  input  muldiv_fn_e req_fn,
  input  logic       req_val,
  input  logic       resp_rdy,
  output logic       req_rdy,
  output logic       resp_val,
  step_ctrl_if.ctrl  ctl
);

  // one iteration per operand bit
  localparam int CNT_W = $clog2(WIDTH);

  muldiv_state_e    state;
  muldiv_fn_e       fn_reg;
  muldiv_fn_e       fn_cur;
  logic [CNT_W-1:0] count;
  logic             accept;
  logic             send;

  //------------------------------------------------------------------------
  // handshakes
  //------------------------------------------------------------------------

  assign req_rdy  = (state == ST_IDLE);
  assign resp_val = (state == ST_DONE);

  // request transfers on val and rdy
  assign accept = req_rdy && req_val;
  // response leaves only when the consumer takes it
  assign send   = resp_val && resp_rdy;

  //------------------------------------------------------------------------
  // strobes and opcode decode
  //------------------------------------------------------------------------

  assign ctl.load = accept;
  assign ctl.step = (state == ST_CALC);

  // live opcode in idle so the operands can be normalized on the load edge
  assign fn_cur        = (state == ST_IDLE) ? req_fn : fn_reg;
  assign ctl.is_signed = (fn_cur == MD_MUL) || (fn_cur == MD_DIV);
  assign ctl.is_mul    = (fn_cur == MD_MUL) || (fn_cur == MD_MULU);

  //------------------------------------------------------------------------
  // state, opcode and counter
  //------------------------------------------------------------------------

  always_ff @(posedge clk) begin
    if (reset) begin
      state  <= ST_IDLE;
      fn_reg <= MD_MUL;
      count  <= '0;
    end else begin
      case (state)
        ST_IDLE: begin
          if (accept) begin
            state  <= ST_CALC;
            fn_reg <= req_fn;
            // WIDTH steps counting down to zero
            count  <= CNT_W'(WIDTH - 1);
          end
        end
        ST_CALC: begin
          count <= count - 1'b1;
          // last step happens in the zero cycle
          if (count == '0) begin
            state <= ST_DONE;
          end
        end
        ST_DONE: begin
          // hold the result until it is taken
          if (send) begin
            state <= ST_IDLE;
          end
        end
        default: state <= ST_IDLE;
      endcase
    end
  end

  // done is left only on a taken response
  assert property (@(posedge clk) disable iff (reset)
    $fell(resp_val) |-> $past(resp_rdy));

  // fixed latency from the accepting edge to the first valid response
  assert property (@(posedge clk) disable iff (reset)
    $rose(resp_val) |-> $past(ctl.load, WIDTH + 1));

endmodule

/* src/sign_adjust.sv */
//--------------------------------------------------------------------------
// sign adjust
// operand magnitudes on the way in, result select and sign fix on the way out
//--------------------------------------------------------------------------

`timescale 1ns/1ps

module sign_adjust #(
  parameter int WIDTH = 32
) (
  input  logic                 clk,
  input  logic                 reset,
  input  logic [WIDTH-1:0]     req_a,
  input  logic [WIDTH-1:0]     req_b,
  output logic [WIDTH-1:0]     abs_a,
  output logic [WIDTH-1:0]     abs_b,
  input  logic [2*WIDTH-1:0]   product,
  input  logic [WIDTH-1:0]     quotient,
  input  logic [WIDTH-1:0]     remainder,
  output logic [2*WIDTH-1:0]   resp_result,
  step_ctrl_if.dpath           ctl
);

  // captured sign flags
  logic               neg_res;
  logic               neg_rem;
  // sign corrected results
  logic [2*WIDTH-1:0] prod_adj;
  logic [WIDTH-1:0]   quo_adj;
  logic [WIDTH-1:0]   rem_adj;

  //------------------------------------------------------------------------
  // operand magnitudes
  //------------------------------------------------------------------------

  // unsigned ops pass straight through
  // the most negative value maps onto itself which is the right magnitude
  assign abs_a = (ctl.is_signed && req_a[WIDTH-1]) ? (~req_a + 1'b1) : req_a;
  assign abs_b = (ctl.is_signed && req_b[WIDTH-1]) ? (~req_b + 1'b1) : req_b;

  // both flags stay zero for unsigned ops
  always_ff @(posedge clk) begin
    if (reset) begin
      neg_res <= 1'b0;
      neg_rem <= 1'b0;
    end else if (ctl.load) begin
      // product and quotient flip when the signs differ
      neg_res <= ctl.is_signed && (req_a[WIDTH-1] ^ req_b[WIDTH-1]);
      // remainder follows the dividend
      neg_rem <= ctl.is_signed && req_a[WIDTH-1];
    end
  end

  //------------------------------------------------------------------------
  // result
  //------------------------------------------------------------------------

  assign prod_adj = neg_res ? (~product + 1'b1) : product;
  assign quo_adj  = neg_res ? (~quotient + 1'b1) : quotient;
  assign rem_adj  = neg_rem ? (~remainder + 1'b1) : remainder;

  // divide packs remainder high and quotient low
  assign resp_result = ctl.is_mul ? prod_adj : {rem_adj, quo_adj};

endmodule

/* src/div_dpath.sv */
//--------------------------------------------------------------------------
// divider datapath
// restoring shift-subtract division, one quotient bit per step
//--------------------------------------------------------------------------

`timescale 1ns/1ps

module div_dpath #(
  parameter int WIDTH = 32
) (
  input  logic             clk,
  input  logic             reset,
  input  logic [WIDTH-1:0] abs_a,
  input  logic [WIDTH-1:0] abs_b,
  output logic [WIDTH-1:0] quotient,
  output logic [WIDTH-1:0] remainder,
  step_ctrl_if.dpath       ctl
);

  // partial remainder in the upper half and quotient bits in the lower half
  // the extra top bit holds the borrow of the trial subtract
  logic [2*WIDTH:0] rq_reg;
  // divisor lined up with the upper half
  logic [2*WIDTH:0] dvs_reg;
  logic [2*WIDTH:0] rq_shift;
  logic [2*WIDTH:0] diff;

  //------------------------------------------------------------------------
  // trial subtract
  //------------------------------------------------------------------------

  assign rq_shift = rq_reg << 1;
  assign diff     = rq_shift - dvs_reg;

  //------------------------------------------------------------------------
  // registers
  //------------------------------------------------------------------------

  always_ff @(posedge clk) begin
    if (reset) begin
      rq_reg  <= '0;
      dvs_reg <= '0;
    end else if (ctl.load) begin
      rq_reg  <= {{(WIDTH + 1){1'b0}}, abs_a};
      dvs_reg <= {1'b0, abs_b, {WIDTH{1'b0}}};
    end else if (ctl.step) begin
      if (diff[2*WIDTH]) begin
        // negative so restore and shift in a zero
        rq_reg <= {rq_shift[2*WIDTH:1], 1'b0};
      end else begin
        // divisor fits so keep the difference
        rq_reg <= {diff[2*WIDTH:1], 1'b1};
      end
    end
  end

  // zero divisor never borrows
  // so the quotient fills with ones and the dividend ends up as remainder
  assign quotient  = rq_reg[WIDTH-1:0];
  assign remainder = rq_reg[2*WIDTH-1:WIDTH];

  // operands are captured only while no iteration is running
  assert property (@(posedge clk) disable iff (reset) !(ctl.load && ctl.step));

endmodule

/* src/mul_dpath.sv */
//--------------------------------------------------------------------------
// multiplier datapath
// shift-add multiply of the operand magnitudes, one bit per step
//--------------------------------------------------------------------------

`timescale 1ns/1ps

module mul_dpath #(
  parameter int WIDTH = 32
) (
  input  logic               clk,
  input  logic               reset,
  input  logic [WIDTH-1:0]   abs_a,
  input  logic [WIDTH-1:0]   abs_b,
  output logic [2*WIDTH-1:0] product,
  step_ctrl_if.dpath         ctl
);

  // multiplicand moves up one place per step
  logic [2*WIDTH-1:0] mcand_reg;
  // multiplier moves down so bit 0 is always the current bit
  logic [WIDTH-1:0]   mplier_reg;
  logic [2*WIDTH-1:0] acc_reg;

  //------------------------------------------------------------------------
  // registers
  //------------------------------------------------------------------------

  // divides leave these untouched
  always_ff @(posedge clk) begin
    if (reset) begin
      mcand_reg  <= '0;
      mplier_reg <= '0;
      acc_reg    <= '0;
    end else if (ctl.is_mul) begin
      if (ctl.load) begin
        mcand_reg  <= {{WIDTH{1'b0}}, abs_a};
        mplier_reg <= abs_b;
        acc_reg    <= '0;
      end else if (ctl.step) begin
        // add the shifted multiplicand for each set multiplier bit
        if (mplier_reg[0]) begin
          acc_reg <= acc_reg + mcand_reg;
        end
        mcand_reg  <= mcand_reg << 1;
        mplier_reg <= mplier_reg >> 1;
      end
    end
  end

  // full magnitude after WIDTH steps
  assign product = acc_reg;

endmodule

/* src/muldiv_top.sv */
//--------------------------------------------------------------------------
// iterative integer multiply/divide unit
// controller plus sign, divide and multiply datapaths
//--------------------------------------------------------------------------

`timescale 1ns/1ps

module muldiv_top
  import muldiv_pkg::*;
#(
  parameter int WIDTH = 32
) (
  input  logic               clk,
  input  logic               reset,
  // request channel
  input  muldiv_fn_e         req_fn,
  input  logic [WIDTH-1:0]   req_a,
  input  logic [WIDTH-1:0]   req_b,
  input  logic               req_val,
  output logic               req_rdy,
  // response channel
  output logic [2*WIDTH-1:0] resp_result,
  output logic               resp_val,
  input  logic               resp_rdy
);

  // operand magnitudes feed both engines
  logic [WIDTH-1:0]   abs_a;
  logic [WIDTH-1:0]   abs_b;
  logic [2*WIDTH-1:0] product;
  logic [WIDTH-1:0]   quotient;
  logic [WIDTH-1:0]   remainder;

  step_ctrl_if ctl_if ();

  muldiv_ctrl #(.WIDTH(WIDTH)) ctrl_i (
    .clk      (clk),
    .reset    (reset),
    .req_fn   (req_fn),
    .req_val  (req_val),
    .resp_rdy (resp_rdy),
    .req_rdy  (req_rdy),
    .resp_val (resp_val),
    .ctl      (ctl_if.ctrl)
  );

  sign_adjust #(.WIDTH(WIDTH)) sign_i (
    .clk         (clk),
    .reset       (reset),
    .req_a       (req_a),
    .req_b       (req_b),
    .abs_a       (abs_a),
    .abs_b       (abs_b),
    .product     (product),
    .quotient    (quotient),
    .remainder   (remainder),
    .resp_result (resp_result),
    .ctl         (ctl_if.dpath)
  );

  div_dpath #(.WIDTH(WIDTH)) div_i (
    .clk       (clk),
    .reset     (reset),
    .abs_a     (abs_a),
    .abs_b     (abs_b),
    .quotient  (quotient),
    .remainder (remainder),
    .ctl       (ctl_if.dpath)
  );

  mul_dpath #(.WIDTH(WIDTH)) mul_i (
    .clk     (clk),
    .reset   (reset),
    .abs_a   (abs_a),
    .abs_b   (abs_b),
    .product (product),
    .ctl     (ctl_if.dpath)
  );

endmodule

/* verification/muldiv_tb.sv */
//--------------------------------------------------------------------------
// muldiv testbench
// replays file vectors against the unit under random response back-pressure
//--------------------------------------------------------------------------

`timescale 1ns/1ps

module muldiv_tb
  import muldiv_pkg::*;
();

  localparam int WIDTH      = 32;
  localparam int MAX_VEC    = 64;
  // first valid response is sampled by this edge after acceptance
  localparam int LATENCY    = WIDTH + 1;
  localparam int WAIT_LIMIT = 200;

  logic               clk;
  logic               reset;
  muldiv_fn_e         req_fn;
  logic [WIDTH-1:0]   req_a;
  logic [WIDTH-1:0]   req_b;
  logic               req_val;
  logic               req_rdy;
  logic [2*WIDTH-1:0] resp_result;
  logic               resp_val;
  logic               resp_rdy = 1'b0;

  // four words per vector: opcode, a, b, expected result
  logic [63:0] vec_mem [0:4*MAX_VEC-1];
  logic [31:0] rng = 32'h2a82;
  int          num_vec;
  int          mismatch_cnt;
  int          timeout_cnt;
  int          protocol_cnt;
  int          resp_cnt;
  bit          timed_out;

  muldiv_top #(.WIDTH(WIDTH)) dut_i (
    .clk         (clk),
    .reset       (reset),
    .req_fn      (req_fn),
    .req_a       (req_a),
    .req_b       (req_b),
    .req_val     (req_val),
    .req_rdy     (req_rdy),
    .resp_result (resp_result),
    .resp_val    (resp_val),
    .resp_rdy    (resp_rdy)
  );

  initial begin
    clk = 1'b0;
    forever #20 clk = ~clk;
  end

  //------------------------------------------------------------------------
  // random back-pressure
  //------------------------------------------------------------------------

  function automatic logic [31:0] lcg_next(input logic [31:0] state);
    return state * 32'd1103515245 + 32'd12345;
  endfunction

  // consumer readiness changes on every rising edge
  always @(posedge clk) begin
    if (reset) begin
      resp_rdy <= 1'b0;
    end else begin
      rng = lcg_next(rng);
      resp_rdy <= rng[16];
    end
  end

  // count every response that actually transfers
  always @(posedge clk) begin
    if (!reset && resp_val && resp_rdy) begin
      resp_cnt++;
    end
  end

  //------------------------------------------------------------------------
  // request and response
  //------------------------------------------------------------------------

  // returns right after the accepting edge
  task automatic send_request(input muldiv_fn_e fn, input logic [WIDTH-1:0] a,
                              input logic [WIDTH-1:0] b);
    int waited = 0;
    @(posedge clk);
    req_fn  <= fn;
    req_a   <= a;
    req_b   <= b;
    req_val <= 1'b1;
    @(negedge clk);
    while (!req_rdy && waited < WAIT_LIMIT) begin
      @(negedge clk);
      waited++;
    end
    if (!req_rdy) begin
      $display("timeout at %0t: req_rdy never went high", $time);
      timeout_cnt++;
      timed_out = 1'b1;
    end
    @(posedge clk);
    req_val <= 1'b0;
  endtask

  task automatic check_response(input int idx, input logic [2*WIDTH-1:0] expected);
    int                 cycles = 0;
    logic [2*WIDTH-1:0] held;
    // busy until the result shows up, no new request may be taken
    do begin
      @(negedge clk);
      cycles++;
      if (req_rdy) begin
        $display("req_rdy went high at %0t while vector %0d was in progress", $time, idx);
        protocol_cnt++;
      end
    end while (!resp_val && cycles < WAIT_LIMIT);
    if (!resp_val) begin
      $display("timeout at %0t: no response for vector %0d", $time, idx);
      timeout_cnt++;
      timed_out = 1'b1;
      return;
    end
    if (cycles != LATENCY) begin
      $display("mismatch at %0t: vector %0d latency expected %0d got %0d",
               $time, idx, LATENCY, cycles);
      mismatch_cnt++;
    end
    if (resp_result !== expected) begin
      $display("mismatch at %0t: vector %0d result expected %h got %h",
               $time, idx, expected, resp_result);
      mismatch_cnt++;
    end
    held   = resp_result;
    cycles = 0;
    // result and handshake must hold while the consumer stalls
    while (!resp_rdy && cycles < WAIT_LIMIT) begin
      @(negedge clk);
      cycles++;
      if (resp_result !== held) begin
        $display("mismatch at %0t: vector %0d result changed under back-pressure, %h to %h",
                 $time, idx, held, resp_result);
        mismatch_cnt++;
      end
      if (!resp_val || req_rdy) begin
        $display("response handshake dropped at %0t before vector %0d was taken",
                 $time, idx);
        protocol_cnt++;
      end
    end
    if (!resp_rdy) begin
      $display("timeout at %0t: consumer never took vector %0d", $time, idx);
      timeout_cnt++;
      timed_out = 1'b1;
      return;
    end
    // the next rising edge transfers the response
    @(posedge clk);
    @(negedge clk);
    if (resp_val || !req_rdy) begin
      $display("unit did not return to idle at %0t after vector %0d", $time, idx);
      protocol_cnt++;
    end
  endtask

  //------------------------------------------------------------------------
  // main sequence
  //------------------------------------------------------------------------

  initial begin
    int idx;
    reset        = 1'b1;
    req_fn       = MD_MUL;
    req_a        = '0;
    req_b        = '0;
    req_val      = 1'b0;
    mismatch_cnt = 0;
    timeout_cnt  = 0;
    protocol_cnt = 0;
    resp_cnt     = 0;
    timed_out    = 1'b0;
    // unread entries get an out-of-range opcode word
    for (idx = 0; idx < 4*MAX_VEC; idx++) begin
      vec_mem[idx] = {32'hf0f0_0000, 32'(idx)};
    end
    $readmemh("verification/muldiv_input.txt", vec_mem);
    num_vec = 0;
    while (num_vec < MAX_VEC && vec_mem[4*num_vec] < 64'd4) begin
      num_vec++;
    end
    if (num_vec == 0) begin
      $display("no test vectors were read from the input file");
      protocol_cnt++;
    end
    repeat (3) @(posedge clk);
    reset <= 1'b0;
    @(negedge clk);
    if (req_rdy !== 1'b1 || resp_val !== 1'b0) begin
      $display("mismatch at %0t: after reset req_rdy %b resp_val %b, expected 1 and 0",
               $time, req_rdy, resp_val);
      mismatch_cnt++;
    end
    for (idx = 0; idx < num_vec && !timed_out; idx++) begin
      send_request(muldiv_fn_e'(vec_mem[4*idx][1:0]), vec_mem[4*idx+1][WIDTH-1:0],
                   vec_mem[4*idx+2][WIDTH-1:0]);
      if (!timed_out) begin
        check_response(idx, vec_mem[4*idx+3]);
      end
    end
    // every vector gives exactly one response
    if (resp_cnt != num_vec) begin
      $display("got %0d responses for %0d vectors", resp_cnt, num_vec);
      protocol_cnt++;
    end
    $display("errors: %0d mismatch, %0d timeout, %0d protocol; %0d of %0d responses",
             mismatch_cnt, timeout_cnt, protocol_cnt, resp_cnt, num_vec);
    if (mismatch_cnt + timeout_cnt + protocol_cnt == 0) begin
      $display("All tests passed");
    end else begin
      $display("Some tests failed");
    end
    $finish;
  end

endmodule

/* verification/muldiv_input.txt */
// columns: opcode (0 mul, 1 mulu, 2 div, 3 divu), a, b, expected result
// divide results hold the remainder in the upper and the quotient in the lower half
1 00000003 00000005 000000000000000f
1 ffffffff ffffffff fffffffe00000001
1 00000000 12345678 0000000000000000
1 00010001 00010001 0000000100020001
1 ffffffff 00000002 00000001fffffffe
0 fffffffd 00000005 fffffffffffffff1
0 fffffff9 fffffffa 000000000000002a
0 00000000 ffffffff 0000000000000000
0 80000000 80000000 4000000000000000
0 80000000 7fffffff c000000080000000
0 7fffffff 7fffffff 3fffffff00000001
0 ffffffff 00000001 ffffffffffffffff
3 00000064 00000007 000000020000000e
3 ffffffff 00000010 0000000f0fffffff
3 00000005 00000000 00000005ffffffff
3 80000000 00000003 000000022aaaaaaa
2 fffffff9 00000002 fffffffffffffffd
2 00000007 fffffffe 00000001fffffffd
2 fffffff9 fffffffe ffffffff00000003
2 80000000 ffffffff 0000000080000000
2 fffffffb 00000000 fffffffb00000001
2 00000005 00000000 00000005ffffffff
2 00000000 00000005 0000000000000000
2 80000000 00000002 00000000c0000000

/* sources.f */
src/muldiv_pkg.sv
src/step_ctrl_if.sv
src/muldiv_ctrl.sv
src/sign_adjust.sv
src/div_dpath.sv
src/mul_dpath.sv
src/muldiv_top.sv
verification/muldiv_tb.sv

/* run.sh */
#!/bin/sh
# build and run the muldiv testbench with Verilator, then scan the log
cd "$(dirname "$0")" || exit 1
rm -f sim.log
verilator --binary --timing --assert -Wno-fatal --timescale 1ns/1ps \
  --top-module muldiv_tb -f sources.f -o muldiv_sim \
  && ./obj_dir/muldiv_sim > sim.log 2>&1 \
  || { echo "build or simulation error"; exit 1; }
grep -q "Some tests failed" sim.log && { echo "FAIL"; exit 1; } || { echo "PASS"; exit 0; }
